//--- logic/ctrl_pkg.sv
/* Board control package
   Settings addresses, settings write bus, control line groups and enums
*/
`default_nettype none

package ctrl_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Settings addresses
   localparam logic [7:0] SR_CLK      = 8'd0;
   localparam logic [7:0] SR_SER      = 8'd1;
   localparam logic [7:0] SR_ADC      = 8'd2;
   localparam logic [7:0] SR_LED      = 8'd3;
   localparam logic [7:0] SR_PHY      = 8'd4;
   localparam logic [7:0] SR_LED_SRC  = 8'd8;
   // Seconds, ticks, load command
   localparam logic [7:0] SR_TIME64   = 8'd192;
   // One-shot count, period
   localparam logic [7:0] SR_SIMTIMER = 8'd198;
   // Mask, clear
   localparam logic [7:0] SR_IRQ      = 8'd200;

   localparam int IRQ_W = 8;

   ////////////////////////////////////////////////////////////////////////////
   // Bus and control line groups
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clock_ctrl_t;

   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   typedef struct packed {
      logic [31:0] secs;
      logic [31:0] ticks;
   } vita_time_t;

   ////////////////////////////////////////////////////////////////////////////
   // Enums
   typedef enum logic {
      LOAD_NOW    = 1'b0,
      LOAD_AT_PPS = 1'b1
   } time_load_e;

   // Bit index in the interrupt vector
   typedef enum logic [2:0] {
      IRQ_ONETIME  = 3'd0,
      IRQ_PERIODIC = 3'd1,
      IRQ_PPS      = 3'd2,
      IRQ_PHY      = 3'd3,
      IRQ_CLK      = 3'd4,
      IRQ_SERDES   = 3'd5
   } irq_src_e;

   typedef enum logic [3:0] {
      RB_PENDING = 4'd0,
      RB_MASK    = 4'd1,
      RB_ENCODED = 4'd2,
      RB_SECS    = 4'd3,
      RB_TICKS   = 4'd4,
      RB_CYCLES  = 4'd5,
      RB_BOARD   = 4'd6
   } rb_word_e;

endpackage

`default_nettype wire

//--- logic/setting_reg.sv
/* Settings register
   Captures the low data bits of a settings write aimed at its own address
*/
`timescale 1ns/100ps
`default_nettype none

module setting_reg #(
   parameter logic [7:0]       ADDR      = 8'd0,
   parameter int               WIDTH     = 32,
   parameter logic [WIDTH-1:0] RESET_VAL = '0
) (
   input  wire                    dsp_clk,
   input  wire                    wb_rst,
   input  wire ctrl_pkg::set_bus_t set_i,
   output logic [WIDTH-1:0]       value_o
);

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         value_o <= RESET_VAL;
      end else if (set_i.stb && (set_i.addr == ADDR)) begin
         value_o <= set_i.data[WIDTH-1:0];
      end
   end

endmodule

`default_nettype wire

//--- logic/board_ctrl.sv
/* Board control registers
   Clock generator, SERDES, ADC and PHY lines plus the LED source mux
*/
`timescale 1ns/100ps
`default_nettype none

module board_ctrl (
   input  wire                          dsp_clk,
   input  wire                          wb_rst,
   input  wire ctrl_pkg::set_bus_t       set_i,
   input  wire                          clk_status_i,
   input  wire                          serdes_link_up_i,
   output ctrl_pkg::clock_ctrl_t        clock_o,
   output ctrl_pkg::serdes_ctrl_t       serdes_o,
   output ctrl_pkg::adc_ctrl_t          adc_o,
   output logic                         phy_reset_n_o,
   output logic [7:0]                   leds_o
);

   logic       phy_reset;
   logic [7:0] led_sw;
   logic [7:0] led_src;
   logic [7:0] led_hw;

   ////////////////////////////////////////////////////////////////////////////
   // Control line registers
   setting_reg #(.ADDR(ctrl_pkg::SR_CLK), .WIDTH(5)) u_sr_clk (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_i(set_i), .value_o(clock_o)
   );

   setting_reg #(.ADDR(ctrl_pkg::SR_SER), .WIDTH(4)) u_sr_ser (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_i(set_i), .value_o(serdes_o)
   );

   setting_reg #(.ADDR(ctrl_pkg::SR_ADC), .WIDTH(4)) u_sr_adc (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_i(set_i), .value_o(adc_o)
   );

   // PHY held in reset while the bit is set
   setting_reg #(.ADDR(ctrl_pkg::SR_PHY), .WIDTH(1)) u_sr_phy (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_i(set_i), .value_o(phy_reset)
   );

   assign phy_reset_n_o = ~phy_reset;

   ////////////////////////////////////////////////////////////////////////////
   // LEDs
   setting_reg #(.ADDR(ctrl_pkg::SR_LED), .WIDTH(8)) u_sr_led (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_i(set_i), .value_o(led_sw)
   );

   setting_reg #(.ADDR(ctrl_pkg::SR_LED_SRC), .WIDTH(8)) u_sr_led_src (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_i(set_i), .value_o(led_src)
   );

   assign led_hw = {6'b0, clk_status_i, serdes_link_up_i};

   // Source bit 1 selects hardware status, 0 the software value
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

`default_nettype wire

//--- logic/event_timer.sv
/* Event timer
   One-shot and periodic single-cycle events, both set through settings writes
*/
`timescale 1ns/100ps
`default_nettype none

module event_timer (
   input  wire                    dsp_clk,
   input  wire                    wb_rst,
   input  wire ctrl_pkg::set_bus_t set_i,
   output logic                   onetime_o,
   output logic                   periodic_o
);

   logic [31:0] onetime_cnt;
   logic [31:0] period;
   logic [31:0] periodic_cnt;
   logic        onetime_wr;
   logic        period_wr;

   assign onetime_wr = set_i.stb && (set_i.addr == ctrl_pkg::SR_SIMTIMER);
   assign period_wr  = set_i.stb && (set_i.addr == ctrl_pkg::SR_SIMTIMER + 8'd1);

   ////////////////////////////////////////////////////////////////////////////
   // One-shot, fires N cycles after the write
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         onetime_cnt <= '0;
         onetime_o   <= 1'b0;
      end else begin
         if (onetime_wr) begin
            onetime_cnt <= set_i.data;
         end else if (onetime_cnt != 32'd0) begin
            onetime_cnt <= onetime_cnt - 32'd1;
         end
         onetime_o <= (onetime_cnt == 32'd1);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Periodic, a period of 0 stops it
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         period       <= '0;
         periodic_cnt <= '0;
         periodic_o   <= 1'b0;
      end else begin
         if (period_wr) begin
            period       <= set_i.data;
            periodic_cnt <= set_i.data;
         end else if (periodic_cnt == 32'd1) begin
            periodic_cnt <= period;
         end else if (periodic_cnt != 32'd0) begin
            periodic_cnt <= periodic_cnt - 32'd1;
         end
         periodic_o <= (periodic_cnt == 32'd1);
      end
   end

   // A one-shot event needs a write or a running count two cycles before
   a_onetime_armed : assert property (
      @(posedge dsp_clk) disable iff (wb_rst)
      onetime_o |-> $past(onetime_wr || (onetime_cnt > 32'd1), 2)
   );

endmodule

`default_nettype wire

//--- logic/vita_time.sv
/* VITA time counter
   64-bit seconds and ticks, loaded at once or on the next PPS rising edge
*/
`timescale 1ns/100ps
`default_nettype none

module vita_time #(
   parameter logic [31:0] TICKS_PER_SEC = 32'd100000000
) (
   input  wire                    dsp_clk,
   input  wire                    wb_rst,
   input  wire ctrl_pkg::set_bus_t set_i,
   input  wire                    pps_i,
   output ctrl_pkg::vita_time_t   time_o,
   output logic                   pps_int_o
);

   logic                  pps_s1;
   logic                  pps_s2;
   logic                  pps_d;
   logic                  pps_edge;
   logic [31:0]           secs_pend;
   logic [31:0]           ticks_pend;
   logic                  cmd_wr;
   ctrl_pkg::time_load_e  load_mode;
   logic                  load_now;
   logic                  armed;
   logic                  do_load;

   ////////////////////////////////////////////////////////////////////////////
   // PPS synchronizer and rising edge
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         pps_s1 <= 1'b0;
         pps_s2 <= 1'b0;
         pps_d  <= 1'b0;
      end else begin
         pps_s1 <= pps_i;
         pps_s2 <= pps_s1;
         pps_d  <= pps_s2;
      end
   end

   assign pps_edge  = pps_s2 & ~pps_d;
   assign pps_int_o = pps_edge;

   ////////////////////////////////////////////////////////////////////////////
   // Pending load values
   always_ff @(posedge dsp_clk) begin
      if (set_i.stb && (set_i.addr == ctrl_pkg::SR_TIME64)) begin
         secs_pend <= set_i.data;
      end
      if (set_i.stb && (set_i.addr == ctrl_pkg::SR_TIME64 + 8'd1)) begin
         ticks_pend <= set_i.data;
      end
   end

   assign cmd_wr    = set_i.stb && (set_i.addr == ctrl_pkg::SR_TIME64 + 8'd2);
   assign load_mode = ctrl_pkg::time_load_e'(set_i.data[0]);

   // Immediate load lands one cycle after the command
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         load_now <= 1'b0;
         armed    <= 1'b0;
      end else begin
         load_now <= cmd_wr && (load_mode == ctrl_pkg::LOAD_NOW);
         if (cmd_wr) begin
            armed <= (load_mode == ctrl_pkg::LOAD_AT_PPS);
         end else if (pps_edge) begin
            armed <= 1'b0;
         end
      end
   end

   assign do_load = load_now || (armed && pps_edge);

   ////////////////////////////////////////////////////////////////////////////
   // Counter
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         time_o <= '0;
      end else if (do_load) begin
         time_o.secs  <= secs_pend;
         time_o.ticks <= ticks_pend;
      end else if (time_o.ticks >= TICKS_PER_SEC - 32'd1) begin
         time_o.ticks <= '0;
         time_o.secs  <= time_o.secs + 32'd1;
      end else begin
         time_o.ticks <= time_o.ticks + 32'd1;
      end
   end

   a_ticks_range : assert property (
      @(posedge dsp_clk) disable iff (wb_rst)
      time_o.ticks < TICKS_PER_SEC
   );

endmodule

`default_nettype wire

//--- logic/irq_ctrl.sv
/* Interrupt controller
   Latches source events into pending bits with mask, clear and priority encode
*/
`timescale 1ns/100ps
`default_nettype none

module irq_ctrl (
   input  wire                         dsp_clk,
   input  wire                         wb_rst,
   input  wire ctrl_pkg::set_bus_t      set_i,
   input  wire [ctrl_pkg::IRQ_W-1:0]   irq_i,
   output logic [31:0]                 pending_o,
   output logic [31:0]                 mask_o,
   output logic [31:0]                 encoded_o,
   output logic                        int_o
);

   localparam int W = ctrl_pkg::IRQ_W;
   localparam logic [W-1:0] ONE = 1;

   // Level sources, latched on their rising edge only
   localparam logic [W-1:0] LEVEL_SRC = (ONE << ctrl_pkg::IRQ_PHY)
                                      | (ONE << ctrl_pkg::IRQ_CLK)
                                      | (ONE << ctrl_pkg::IRQ_SERDES);

   logic [W-1:0] irq_d;
   logic [W-1:0] irq_event;
   logic [W-1:0] clr;
   logic [W-1:0] pending;
   logic [W-1:0] mask;

   setting_reg #(.ADDR(ctrl_pkg::SR_IRQ), .WIDTH(W)) u_sr_mask (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_i(set_i), .value_o(mask)
   );

   assign clr = (set_i.stb && (set_i.addr == ctrl_pkg::SR_IRQ + 8'd1)) ?
                set_i.data[W-1:0] : '0;

   // Pulse sources pass straight, level sources edge detected
   assign irq_event = irq_i & ~(irq_d & LEVEL_SRC);

   ////////////////////////////////////////////////////////////////////////////
   // Pending bits, a new event wins over clear
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         irq_d   <= '0;
         pending <= '0;
         int_o   <= 1'b0;
      end else begin
         irq_d   <= irq_i;
         pending <= (pending & ~clr) | irq_event;
         int_o   <= |(pending & mask);
      end
   end

   // Highest pending index plus one
   always_comb begin
      encoded_o = '0;
      for (int i = 0; i < W; i++) begin
         if (pending[i]) begin
            encoded_o = 32'(i + 1);
         end
      end
   end

   assign pending_o = {{(32 - W){1'b0}}, pending};
   assign mask_o    = {{(32 - W){1'b0}}, mask};

   // An interrupt needs a bit that was latched and not cleared before it
   a_int_cause : assert property (
      @(posedge dsp_clk) disable iff (wb_rst)
      int_o |-> $past(|((pending & ~clr) | irq_event), 2)
   );

endmodule

`default_nettype wire

//--- logic/status_readback.sv
/* Status readback
   Registered word select with one cycle latency and a free-running cycle count
*/
`timescale 1ns/100ps
`default_nettype none

module status_readback (
   input  wire                          dsp_clk,
   input  wire                          wb_rst,
   input  wire [3:0]                    rb_addr_i,
   input  wire [31:0]                   pending_i,
   input  wire [31:0]                   mask_i,
   input  wire [31:0]                   encoded_i,
   input  wire ctrl_pkg::vita_time_t     time_i,
   input  wire [31:0]                   board_status_i,
   output logic [31:0]                  rb_data_o
);

   logic [31:0] cycle_cnt;

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         cycle_cnt <= '0;
      end else begin
         cycle_cnt <= cycle_cnt + 32'd1;
      end
   end

   // Unused addresses read as zero
   always_ff @(posedge dsp_clk) begin
      case (ctrl_pkg::rb_word_e'(rb_addr_i))
         ctrl_pkg::RB_PENDING : rb_data_o <= pending_i;
         ctrl_pkg::RB_MASK    : rb_data_o <= mask_i;
         ctrl_pkg::RB_ENCODED : rb_data_o <= encoded_i;
         ctrl_pkg::RB_SECS    : rb_data_o <= time_i.secs;
         ctrl_pkg::RB_TICKS   : rb_data_o <= time_i.ticks;
         ctrl_pkg::RB_CYCLES  : rb_data_o <= cycle_cnt;
         ctrl_pkg::RB_BOARD   : rb_data_o <= board_status_i;
         default              : rb_data_o <= '0;
      endcase
   end

endmodule

`default_nettype wire

//--- logic/ctrl_core_top.sv
/* Board control core
   Settings port in, board control lines, interrupt and status readback out
*/
`timescale 1ns/100ps
`default_nettype none

module ctrl_core_top #(
   parameter logic [31:0] TICKS_PER_SEC = 32'd100000000
) (
   input  wire                          dsp_clk,
   input  wire                          wb_rst,
   input  wire ctrl_pkg::set_bus_t       set_i,
   input  wire                          pps_i,
   input  wire                          clk_status_i,
   input  wire                          serdes_link_up_i,
   input  wire                          phy_int_n_i,
   input  wire [3:0]                    rb_addr_i,
   output ctrl_pkg::clock_ctrl_t        clock_o,
   output ctrl_pkg::serdes_ctrl_t       serdes_o,
   output ctrl_pkg::adc_ctrl_t          adc_o,
   output logic                         phy_reset_n_o,
   output logic [7:0]                   leds_o,
   output logic                         int_o,
   output logic [31:0]                  rb_data_o
);

   logic                        onetime;
   logic                        periodic;
   logic                        pps_int;
   logic [ctrl_pkg::IRQ_W-1:0]  irq_vec;
   ctrl_pkg::vita_time_t        vita_time_q;
   logic [31:0]                 pending;
   logic [31:0]                 mask;
   logic [31:0]                 encoded;
   logic [31:0]                 board_status;

   board_ctrl u_board_ctrl (
      .dsp_clk          (dsp_clk),
      .wb_rst           (wb_rst),
      .set_i            (set_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .clock_o          (clock_o),
      .serdes_o         (serdes_o),
      .adc_o            (adc_o),
      .phy_reset_n_o    (phy_reset_n_o),
      .leds_o           (leds_o)
   );

   event_timer u_event_timer (
      .dsp_clk    (dsp_clk),
      .wb_rst     (wb_rst),
      .set_i      (set_i),
      .onetime_o  (onetime),
      .periodic_o (periodic)
   );

   vita_time #(.TICKS_PER_SEC(TICKS_PER_SEC)) u_vita_time (
      .dsp_clk   (dsp_clk),
      .wb_rst    (wb_rst),
      .set_i     (set_i),
      .pps_i     (pps_i),
      .time_o    (vita_time_q),
      .pps_int_o (pps_int)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Interrupt sources, PHY line is active low
   always_comb begin
      irq_vec                         = '0;
      irq_vec[ctrl_pkg::IRQ_ONETIME]  = onetime;
      irq_vec[ctrl_pkg::IRQ_PERIODIC] = periodic;
      irq_vec[ctrl_pkg::IRQ_PPS]      = pps_int;
      irq_vec[ctrl_pkg::IRQ_PHY]      = ~phy_int_n_i;
      irq_vec[ctrl_pkg::IRQ_CLK]      = clk_status_i;
      irq_vec[ctrl_pkg::IRQ_SERDES]   = serdes_link_up_i;
   end

   irq_ctrl u_irq_ctrl (
      .dsp_clk   (dsp_clk),
      .wb_rst    (wb_rst),
      .set_i     (set_i),
      .irq_i     (irq_vec),
      .pending_o (pending),
      .mask_o    (mask),
      .encoded_o (encoded),
      .int_o     (int_o)
   );

   assign board_status = {30'b0, clk_status_i, serdes_link_up_i};

   status_readback u_status_readback (
      .dsp_clk        (dsp_clk),
      .wb_rst         (wb_rst),
      .rb_addr_i      (rb_addr_i),
      .pending_i      (pending),
      .mask_i         (mask),
      .encoded_i      (encoded),
      .time_i         (vita_time_q),
      .board_status_i (board_status),
      .rb_data_o      (rb_data_o)
   );

endmodule

`default_nettype wire

//--- bench/ctrl_core_checker.sv
/* Testbench checker
   Compares DUT outputs against expected values and keeps the error count
*/
`timescale 1ns/100ps
`default_nettype none

module ctrl_core_checker (
   input  wire        dsp_clk,
   input  wire        chk_en_i,
   input  wire [3:0]  chk_sel_i,
   input  wire [31:0] chk_exp_i,
   input  wire [4:0]  clock_i,
   input  wire [3:0]  serdes_i,
   input  wire [3:0]  adc_i,
   input  wire        phy_reset_n_i,
   input  wire [7:0]  leds_i,
   input  wire        int_i,
   input  wire [31:0] rb_data_i,
   input  wire        test_end_i,
   input  wire [3:0]  test_id_i,
   input  wire        finish_i,
   output logic [15:0] error_count_o
);

   int          checks = 0;
   int          test_errs = 0;
   logic [31:0] cyc_first = '0;

   initial error_count_o = '0;

   task automatic compare(input string name, input logic [31:0] act, input logic [31:0] exp);
      checks++;
      if (act !== exp) begin
         $display("** Error: %s = 0x%h, expected 0x%h", name, act, exp);
         error_count_o <= error_count_o + 16'd1;
         test_errs++;
      end
   endtask

   always @(posedge dsp_clk) begin
      if (chk_en_i) begin
         case (chk_sel_i)
            4'd0: compare("clock_o", {27'b0, clock_i}, chk_exp_i);
            4'd1: compare("serdes_o", {28'b0, serdes_i}, chk_exp_i);
            4'd2: compare("adc_o", {28'b0, adc_i}, chk_exp_i);
            4'd3: compare("phy_reset_n_o", {31'b0, phy_reset_n_i}, chk_exp_i);
            4'd4: compare("leds_o", {24'b0, leds_i}, chk_exp_i);
            4'd5: compare("int_o", {31'b0, int_i}, chk_exp_i);
            4'd6: compare("rb_data_o", rb_data_i, chk_exp_i);
            4'd7: cyc_first <= rb_data_i;
            // Difference between two cycle counter reads
            4'd8: compare("rb_data_o cycle delta", rb_data_i - cyc_first, chk_exp_i);
            default: begin
               checks++;
               error_count_o <= error_count_o + 16'd1;
               test_errs++;
               case (chk_exp_i)
                  32'd1: $display("One-shot event came too early or too late");
                  32'd2: $display("Interrupt output did not rise with the mask set");
                  default: $display("Periodic event did not come back after a clear");
               endcase
            end
         endcase
      end
      if (test_end_i) begin
         $display("Test %0d finished with %0d errors", test_id_i, test_errs);
         test_errs = 0;
      end
      if (finish_i) begin
         $display("Checks run: %0d, errors: %0d", checks, error_count_o);
      end
   end

endmodule

`default_nettype wire

//--- bench/ctrl_core_tb.sv
/* Board control core testbench
   Drives settings, PPS and status lines, and checks outputs through the checker
*/
`timescale 1ns/100ps
`default_nettype none

module ctrl_core_tb;

   localparam logic [31:0] TPS = 32'd50;
   // Six short tests take well under a thousand cycles
   localparam int TIMEOUT_CYCLES = 4000;
   localparam logic [3:0] SEL_RB = 4'd6;

   logic dsp_clk = 1'b0;
   logic wb_rst = 1'b1;
   ctrl_pkg::set_bus_t set_bus = '0;
   logic pps = 1'b0;
   logic clk_status = 1'b0;
   logic link_up = 1'b0;
   logic phy_int_n = 1'b1;
   logic [3:0] rb_addr = '0;
   ctrl_pkg::clock_ctrl_t clock;
   ctrl_pkg::serdes_ctrl_t serdes;
   ctrl_pkg::adc_ctrl_t adc;
   logic phy_reset_n;
   logic int_out;
   logic [7:0] leds;
   logic [31:0] rb_data;
   logic chk_en = 1'b0;
   logic test_end = 1'b0;
   logic finish = 1'b0;
   logic [3:0] chk_sel = '0;
   logic [3:0] test_id = '0;
   logic [31:0] chk_exp = '0;
   logic [15:0] err_count;
   int cyc = 0;
   int run_cycles = 0;
   integer seed = 32'hc240_97a2;

   always #5 dsp_clk = ~dsp_clk;

   ctrl_core_top #(.TICKS_PER_SEC(TPS)) u_dut (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .set_i(set_bus), .pps_i(pps),
      .clk_status_i(clk_status), .serdes_link_up_i(link_up), .phy_int_n_i(phy_int_n),
      .rb_addr_i(rb_addr), .clock_o(clock), .serdes_o(serdes), .adc_o(adc),
      .phy_reset_n_o(phy_reset_n), .leds_o(leds), .int_o(int_out), .rb_data_o(rb_data)
   );

   ctrl_core_checker u_checker (
      .dsp_clk(dsp_clk), .chk_en_i(chk_en), .chk_sel_i(chk_sel), .chk_exp_i(chk_exp),
      .clock_i(clock), .serdes_i(serdes), .adc_i(adc), .phy_reset_n_i(phy_reset_n),
      .leds_i(leds), .int_i(int_out), .rb_data_i(rb_data), .test_end_i(test_end),
      .test_id_i(test_id), .finish_i(finish), .error_count_o(err_count)
   );

   always @(posedge dsp_clk) begin
      run_cycles <= run_cycles + 1;
      if (run_cycles >= TIMEOUT_CYCLES) begin
         $display("Run stopped after %0d cycles without finishing", run_cycles);
         $display("Done: errors found");
         $finish;
      end
   end

   // Time after n cycles of counting
   function automatic ctrl_pkg::vita_time_t expect_time(input ctrl_pkg::vita_time_t t,
                                                        input int n);
      ctrl_pkg::vita_time_t r;
      r = t;
      for (int i = 0; i < n; i++) begin
         if (r.ticks >= TPS - 1) begin
            r.ticks = '0;
            r.secs  = r.secs + 32'd1;
         end else begin
            r.ticks = r.ticks + 32'd1;
         end
      end
      return r;
   endfunction

   task automatic step;
      @(posedge dsp_clk);
      #1;
      cyc++;
   endtask

   task automatic write_set(input logic [7:0] a, input logic [31:0] d);
      set_bus.stb  = 1'b1;
      set_bus.addr = a;
      set_bus.data = d;
      step();
      set_bus.stb = 1'b0;
   endtask

   task automatic check(input logic [3:0] sel, input logic [31:0] exp);
      chk_en  = 1'b1;
      chk_sel = sel;
      chk_exp = exp;
      step();
      chk_en = 1'b0;
   endtask

   task automatic read_check(input logic [3:0] a, input logic [31:0] exp);
      rb_addr = a;
      step();
      check(SEL_RB, exp);
   endtask

   task automatic close_test(input logic [3:0] id);
      test_end = 1'b1;
      test_id  = id;
      step();
      test_end = 1'b0;
   endtask

   // Wait for a pending bit on the readback port, returns cycles waited
   task automatic wait_pending(input int bit_idx, input int limit, output int d);
      int start;
      start = cyc;
      d = 0;
      while (!rb_data[bit_idx] && d < limit) begin
         step();
         d = cyc - start;
      end
      if (!rb_data[bit_idx]) d = limit + 1;
   endtask

   initial begin : stimulus
      logic [7:0] addr_list [8];
      logic [7:0] a;
      logic [7:0] src;
      logic [7:0] sw;
      logic [7:0] hw;
      logic [7:0] led_exp;
      logic [31:0] d;
      logic [4:0] clk_m;
      logic [3:0] ser_m;
      logic [3:0] adc_m;
      logic phy_m;
      ctrl_pkg::vita_time_t base;
      ctrl_pkg::vita_time_t exp_t;
      int load_cyc;
      int wait_d;
      int i;
      addr_list = '{8'd0, 8'd1, 8'd2, 8'd4, 8'd5, 8'd6, 8'd7, 8'd9};
      clk_m = '0;
      ser_m = '0;
      adc_m = '0;
      phy_m = 1'b0;
      repeat (2) @(posedge dsp_clk);
      #1 wb_rst = 1'b0;

      ////////////////////////////////////////////////////////////////////////
      // 1: control registers, reset values first
      check(4'd5, 32'd0);
      for (int k = 0; k < 12; k++) begin
         a = addr_list[3'($random(seed))];
         d = $random(seed);
         write_set(a, d);
         if (a == ctrl_pkg::SR_CLK) clk_m = d[4:0];
         if (a == ctrl_pkg::SR_SER) ser_m = d[3:0];
         if (a == ctrl_pkg::SR_ADC) adc_m = d[3:0];
         if (a == ctrl_pkg::SR_PHY) phy_m = d[0];
         check(4'd0, {27'b0, clk_m});
         check(4'd1, {28'b0, ser_m});
         check(4'd2, {28'b0, adc_m});
         check(4'd3, {31'b0, ~phy_m});
      end
      close_test(4'd1);

      ////////////////////////////////////////////////////////////////////////
      // 2: LED source mux
      check(4'd4, 32'd0);
      for (int k = 0; k < 10; k++) begin
         src = 8'($random(seed));
         sw  = 8'($random(seed));
         write_set(ctrl_pkg::SR_LED, {24'b0, sw});
         write_set(ctrl_pkg::SR_LED_SRC, {24'b0, src});
         clk_status = 1'($random(seed));
         link_up    = 1'($random(seed));
         hw = {6'b0, clk_status, link_up};
         // Per bit, source 1 picks hardware status
         for (int b = 0; b < 8; b++) begin
            led_exp[b] = src[b] ? hw[b] : sw[b];
         end
         check(4'd4, {24'b0, led_exp});
      end
      clk_status = 1'b0;
      link_up    = 1'b0;
      close_test(4'd2);

      ////////////////////////////////////////////////////////////////////////
      // 3: immediate load, ticks wrap into secs
      base.secs  = 32'd1000;
      base.ticks = 32'd40;
      write_set(ctrl_pkg::SR_TIME64, base.secs);
      write_set(ctrl_pkg::SR_TIME64 + 8'd1, base.ticks);
      write_set(ctrl_pkg::SR_TIME64 + 8'd2, 32'd0);
      load_cyc = cyc;
      repeat (12) step();
      rb_addr = ctrl_pkg::RB_SECS;
      step();
      exp_t = expect_time(base, cyc - load_cyc - 2);
      check(SEL_RB, exp_t.secs);
      rb_addr = ctrl_pkg::RB_TICKS;
      step();
      exp_t = expect_time(base, cyc - load_cyc - 2);
      check(SEL_RB, exp_t.ticks);
      close_test(4'd3);

      ////////////////////////////////////////////////////////////////////////
      // 4: load armed for the next PPS
      write_set(ctrl_pkg::SR_IRQ + 8'd1, 32'hff);
      write_set(ctrl_pkg::SR_TIME64, 32'd77);
      write_set(ctrl_pkg::SR_TIME64 + 8'd1, 32'd0);
      write_set(ctrl_pkg::SR_TIME64 + 8'd2, 32'd1);
      repeat (4) step();
      rb_addr = ctrl_pkg::RB_SECS;
      step();
      exp_t = expect_time(base, cyc - load_cyc - 2);
      check(SEL_RB, exp_t.secs);
      pps = 1'b1;
      repeat (6) step();
      pps = 1'b0;
      read_check(ctrl_pkg::RB_SECS, 32'd77);
      read_check(ctrl_pkg::RB_PENDING, 32'h4);
      close_test(4'd4);

      ////////////////////////////////////////////////////////////////////////
      // 5: one-shot, mask, clear, periodic
      write_set(ctrl_pkg::SR_IRQ + 8'd1, 32'hff);
      write_set(ctrl_pkg::SR_IRQ, 32'h1);
      rb_addr = ctrl_pkg::RB_PENDING;
      write_set(ctrl_pkg::SR_SIMTIMER, 32'd10);
      wait_pending(0, 13, wait_d);
      if (wait_d <= 10 || wait_d > 13) check(4'd9, 32'd1);
      i = 0;
      while (!int_out && i < 5) begin
         step();
         i++;
      end
      if (!int_out) check(4'd9, 32'd2);
      write_set(ctrl_pkg::SR_IRQ + 8'd1, 32'h1);
      step();
      check(4'd5, 32'd0);
      write_set(ctrl_pkg::SR_SIMTIMER + 8'd1, 32'd8);
      repeat (3) begin
         wait_pending(1, 20, wait_d);
         if (wait_d > 20) check(4'd9, 32'd3);
         write_set(ctrl_pkg::SR_IRQ + 8'd1, 32'h2);
         step();
      end
      write_set(ctrl_pkg::SR_SIMTIMER + 8'd1, 32'd0);
      repeat (3) step();
      write_set(ctrl_pkg::SR_IRQ, 32'h0);
      close_test(4'd5);

      ////////////////////////////////////////////////////////////////////////
      // 6: level edges, encoder, cycle counter
      write_set(ctrl_pkg::SR_IRQ + 8'd1, 32'hff);
      clk_status = 1'b1;
      phy_int_n  = 1'b0;
      repeat (3) step();
      read_check(ctrl_pkg::RB_PENDING, 32'h18);
      read_check(ctrl_pkg::RB_ENCODED, 32'd5);
      rb_addr = ctrl_pkg::RB_CYCLES;
      step();
      check(4'd7, 32'd0);
      repeat (8) step();
      check(4'd8, 32'd9);
      close_test(4'd6);

      finish = 1'b1;
      step();
      finish = 1'b0;
      if (err_count == 16'd0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
logic/ctrl_pkg.sv
logic/setting_reg.sv
logic/board_ctrl.sv
logic/event_timer.sv
logic/vita_time.sv
logic/irq_ctrl.sv
logic/status_readback.sv
logic/ctrl_core_top.sv
bench/ctrl_core_checker.sv
bench/ctrl_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the board control core simulation with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f flist.f --top-module ctrl_core_tb \
   -o ctrl_core_sim > build.log 2>&1 \
   && ./obj_dir/ctrl_core_sim > sim.log 2>&1

grep -q "^Done: no errors$" sim.log 2>/dev/null \
   && echo "Simulation passed" \
   || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
